//--- verilog/cacheGeometryPkg.sv
package cacheGeometryPkg;

    // Physical address and line layout
    localparam int addrWidth = 32;
    localparam int lineBytes = 16;
    localparam int offsetWidth = $clog2(lineBytes);
    localparam int defaultIndexWidth = 6;

    localparam int wordWidth = 32;
    localparam int lineWidth = lineBytes * 8;
    localparam int lineAddrWidth = addrWidth - offsetWidth;

    typedef logic [wordWidth-1:0] Word;

    typedef logic [addrWidth-1:0] PhysAddr;

    // Address with the byte offset removed
    typedef logic [lineAddrWidth-1:0] LineAddr;

    typedef logic [lineWidth-1:0] LineData;

    // Tag keeps the whole line address, so the index width never changes it
    typedef struct packed {
        logic valid;
        LineAddr tag;
    } TagEntry;

endpackage

//--- verilog/lsuOpsPkg.sv
package lsuOpsPkg;

    typedef enum logic [2:0] {
        cmdNone = 3'd0,
        cmdLoad = 3'd1,
        cmdStore = 3'd2,
        cmdAtomic = 3'd3,
        cmdInvalidate = 3'd4
    } LsuCommand;

    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } AccessSize;

    typedef enum logic [3:0] {
        opSwap = 4'd0,
        opAdd = 4'd1,
        opXor = 4'd2,
        opAnd = 4'd3,
        opOr = 4'd4,
        opMin = 4'd5,
        opMax = 4'd6,
        opMinu = 4'd7,
        opMaxu = 4'd8
    } AtomicOp;

    // Commands from the controller to the line-transfer engine
    typedef enum logic [1:0] {
        xferIdle = 2'd0,
        xferFetch = 2'd1,
        xferWriteThrough = 2'd2,
        xferInvalidate = 2'd3
    } TransferCommand;

    // New memory word of an atomic op
    function automatic cacheGeometryPkg::Word atomicResult(
        AtomicOp op,
        cacheGeometryPkg::Word regValue,
        cacheGeometryPkg::Word memValue
    );
        logic signedLess;
        logic unsignedLess;
        signedLess = $signed(regValue) < $signed(memValue);
        unsignedLess = regValue < memValue;
        case (op)
            opSwap: atomicResult = regValue;
            opAdd: atomicResult = regValue + memValue;
            opXor: atomicResult = regValue ^ memValue;
            opAnd: atomicResult = regValue & memValue;
            opOr: atomicResult = regValue | memValue;
            opMin: atomicResult = signedLess ? regValue : memValue;
            opMax: atomicResult = signedLess ? memValue : regValue;
            opMinu: atomicResult = unsignedLess ? regValue : memValue;
            opMaxu: atomicResult = unsignedLess ? memValue : regValue;
            default: atomicResult = memValue;
        endcase
    endfunction

endpackage

//--- verilog/arrayAccessIf.sv
`timescale 1ns/1ps

interface arrayAccessIf #(
    parameter type entryType = logic,
    parameter int indexWidth = cacheGeometryPkg::defaultIndexWidth
);

    logic [indexWidth-1:0] index;
    logic writeEnable;
    entryType writeEntry;

    // Valid one cycle after index
    entryType readEntry;

    modport controller (
        output index, writeEnable, writeEntry,
        input readEntry
    );

    modport array (
        input index, writeEnable, writeEntry,
        output readEntry
    );

endinterface

//--- verilog/lineTransferIf.sv
`timescale 1ns/1ps

interface lineTransferIf #(
    parameter int indexWidth = cacheGeometryPkg::defaultIndexWidth
);
    import cacheGeometryPkg::*;
    import lsuOpsPkg::*;

    // Held by the controller until done
    TransferCommand command;
    LineAddr lineAddr;
    LineData writeLine;

    // One-cycle pulse, fillLine valid with it on a fetch
    logic done;
    LineData fillLine;

    // Tag clear during invalidate
    logic [indexWidth-1:0] sweepIndex;
    logic sweepWrite;

    modport controller (
        output command, lineAddr, writeLine,
        input done, fillLine, sweepIndex, sweepWrite
    );

    modport engine (
        input command, lineAddr, writeLine,
        output done, fillLine, sweepIndex, sweepWrite
    );

endinterface

//--- verilog/syncArray.sv
`timescale 1ns/1ps

module syncArray #(
    parameter type entryType = logic,
    parameter int indexWidth = cacheGeometryPkg::defaultIndexWidth,
    parameter bit clearOnReset = 1'b0
) (
    input logic clk,
    input logic rst,
    arrayAccessIf.array port
);

    localparam int depth = 1 << indexWidth;

    entryType entries [depth];

    always_ff @(posedge clk) begin
        if (clearOnReset && rst) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= '0;
            end
        end else if (port.writeEnable) begin
            entries[port.index] <= port.writeEntry;
        end
    end

    // Registered read, returns the old entry on a same-cycle write
    always_ff @(posedge clk) begin
        port.readEntry <= entries[port.index];
    end

endmodule

//--- verilog/lineTransfer.sv
`timescale 1ns/1ps

module lineTransfer #(
    parameter int indexWidth = cacheGeometryPkg::defaultIndexWidth
) (
    input logic clk,
    input logic rst,
    lineTransferIf.engine xfer,
    output cacheGeometryPkg::PhysAddr memAddr,
    output logic memReadReq,
    input logic memReadGrant,
    input cacheGeometryPkg::LineData memReadData,
    output logic memWriteReq,
    input logic memWriteGrant,
    output cacheGeometryPkg::LineData memWriteData
);
    import cacheGeometryPkg::*;
    import lsuOpsPkg::*;

    typedef enum logic [1:0] {
        engIdle,
        engRead,
        engWrite,
        engSweep
    } EngineState;

    EngineState state;
    logic [indexWidth-1:0] sweepCount;
    logic lastSweep;
    logic readDone;
    logic writeDone;

    assign lastSweep = (state == engSweep) && (sweepCount == '1);
    assign readDone = (state == engRead) && memReadGrant;
    assign writeDone = (state == engWrite) && memWriteGrant;

    // Request levels follow the state, so they drop the cycle after a grant
    assign memReadReq = (state == engRead);
    assign memWriteReq = (state == engWrite);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= engIdle;
            sweepCount <= '0;
        end else begin
            case (state)
                engIdle: begin
                    sweepCount <= '0;
                    case (xfer.command)
                        xferFetch: state <= engRead;
                        xferWriteThrough: state <= engWrite;
                        xferInvalidate: state <= engSweep;
                        default: state <= engIdle;
                    endcase
                end
                engRead: begin
                    if (memReadGrant) begin
                        state <= engIdle;
                    end
                end
                engWrite: begin
                    if (memWriteGrant) begin
                        state <= engIdle;
                    end
                end
                default: begin
                    sweepCount <= sweepCount + 1'b1;
                    if (lastSweep) begin
                        state <= engIdle;
                    end
                end
            endcase
        end
    end

    // Captured while idle, then stable for the whole request
    always_ff @(posedge clk) begin
        if (state == engIdle) begin
            memAddr <= {xfer.lineAddr, {offsetWidth{1'b0}}};
            memWriteData <= xfer.writeLine;
        end
    end

    always_comb begin
        xfer.done = readDone || writeDone || lastSweep;
        xfer.fillLine = memReadData;
        xfer.sweepIndex = sweepCount;
        xfer.sweepWrite = (state == engSweep);
    end

endmodule

//--- verilog/lsuControl.sv
`timescale 1ns/1ps

module lsuControl #(
    parameter int indexWidth = cacheGeometryPkg::defaultIndexWidth
) (
    input logic clk,
    input logic rst,
    input logic enable,
    input lsuOpsPkg::LsuCommand command,
    input lsuOpsPkg::AccessSize size,
    input logic isUnsigned,
    input lsuOpsPkg::AtomicOp atomicOp,
    input cacheGeometryPkg::PhysAddr base,
    input cacheGeometryPkg::Word imm,
    input cacheGeometryPkg::Word storeData,
    output logic done,
    output cacheGeometryPkg::Word result,
    arrayAccessIf.controller tagPort,
    arrayAccessIf.controller dataPort,
    lineTransferIf.controller xfer
);
    import cacheGeometryPkg::*;
    import lsuOpsPkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stFetch,
        stRetry,
        stWriteThrough,
        stInvalidate
    } ControlState;

    localparam int indexLsb = offsetWidth;
    localparam int indexMsb = offsetWidth + indexWidth - 1;

    ControlState state;
    ControlState nextState;

    PhysAddr addr;
    PhysAddr genAddr;
    LineAddr lineAddr;
    logic [offsetWidth-1:0] offset;
    logic [indexWidth-1:0] lookupIndex;

    // Payload kept across the write-through
    LineData lineReg;
    Word savedWord;

    TagEntry readTag;
    TagEntry fillTag;
    LineData readLine;
    LineData mergedLine;
    logic hit;
    logic isAccess;
    logic isWrite;

    Word oldWord;
    Word newWord;
    Word loadValue;
    logic [15:0] halfValue;
    logic [7:0] byteValue;

    assign genAddr = base + imm;
    assign lineAddr = addr[addrWidth-1:offsetWidth];
    assign offset = addr[offsetWidth-1:0];

    // The new address indexes the arrays while idle
    assign lookupIndex = (state == stIdle) ? genAddr[indexMsb:indexLsb] : addr[indexMsb:indexLsb];

    assign readTag = tagPort.readEntry;
    assign readLine = dataPort.readEntry;
    assign hit = readTag.valid && (readTag.tag == lineAddr);

    assign isAccess = command inside {cmdLoad, cmdStore, cmdAtomic};
    assign isWrite = command inside {cmdStore, cmdAtomic};

    // Load extraction
    assign oldWord = readLine[offset[offsetWidth-1:2]*32 +: 32];
    assign halfValue = readLine[offset[offsetWidth-1:1]*16 +: 16];
    assign byteValue = readLine[offset*8 +: 8];

    always_comb begin
        case (size)
            sizeByte: loadValue = isUnsigned ? {24'b0, byteValue} : {{24{byteValue[7]}}, byteValue};
            sizeHalf: loadValue = isUnsigned ? {16'b0, halfValue} : {{16{halfValue[15]}}, halfValue};
            default: loadValue = oldWord;
        endcase
    end

    // Store merge into the line that was just read
    assign newWord = atomicResult(atomicOp, storeData, oldWord);

    always_comb begin
        mergedLine = readLine;
        if (command == cmdAtomic) begin
            mergedLine[offset[offsetWidth-1:2]*32 +: 32] = newWord;
        end else begin
            case (size)
                sizeByte: mergedLine[offset*8 +: 8] = storeData[7:0];
                sizeHalf: mergedLine[offset[offsetWidth-1:1]*16 +: 16] = storeData[15:0];
                default: mergedLine[offset[offsetWidth-1:2]*32 +: 32] = storeData;
            endcase
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (enable) begin
                    nextState = (command == cmdInvalidate) ? stInvalidate : stLookup;
                end
            end
            stLookup: begin
                if (!isAccess) begin
                    nextState = stIdle;
                end else if (!hit) begin
                    nextState = stFetch;
                end else if (isWrite) begin
                    nextState = stWriteThrough;
                end else begin
                    nextState = stIdle;
                end
            end
            stFetch: begin
                if (xfer.done) begin
                    nextState = stRetry;
                end
            end
            // Arrays were written last cycle, read them again
            stRetry: nextState = stLookup;
            default: begin
                if (xfer.done) begin
                    nextState = stIdle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle) begin
            addr <= genAddr;
        end
        if (state == stLookup && hit) begin
            lineReg <= mergedLine;
            savedWord <= oldWord;
        end
    end

    assign done = ((state == stLookup) && (!isAccess || (hit && !isWrite)))
        || ((state == stWriteThrough || state == stInvalidate) && xfer.done);

    // Atomics return the old word at the end of the write-through
    assign result = (state == stLookup) ? loadValue : savedWord;

    assign fillTag = '{valid: 1'b1, tag: lineAddr};

    always_comb begin
        tagPort.index = lookupIndex;
        tagPort.writeEnable = (state == stFetch) && xfer.done;
        tagPort.writeEntry = fillTag;
        if (state == stInvalidate) begin
            tagPort.index = xfer.sweepIndex;
            tagPort.writeEnable = xfer.sweepWrite;
            tagPort.writeEntry = '0;
        end
    end

    always_comb begin
        dataPort.index = lookupIndex;
        dataPort.writeEnable = ((state == stFetch) && xfer.done)
            || ((state == stLookup) && isWrite && hit);
        dataPort.writeEntry = (state == stFetch) ? xfer.fillLine : mergedLine;
    end

    always_comb begin
        xfer.lineAddr = lineAddr;
        xfer.writeLine = lineReg;
        case (state)
            stFetch: xfer.command = xferFetch;
            stWriteThrough: xfer.command = xferWriteThrough;
            stInvalidate: xfer.command = xferInvalidate;
            default: xfer.command = xferIdle;
        endcase
    end

endmodule

//--- verilog/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit #(
    parameter int indexWidth = cacheGeometryPkg::defaultIndexWidth
) (
    input logic clk,
    input logic rst,

    // Requester side
    input logic enable,
    input lsuOpsPkg::LsuCommand command,
    input lsuOpsPkg::AccessSize size,
    input logic isUnsigned,
    input lsuOpsPkg::AtomicOp atomicOp,
    input cacheGeometryPkg::PhysAddr base,
    input cacheGeometryPkg::Word imm,
    input cacheGeometryPkg::Word storeData,
    output logic done,
    output cacheGeometryPkg::Word result,

    // Memory side
    output cacheGeometryPkg::PhysAddr memAddr,
    output logic memReadReq,
    input logic memReadGrant,
    input cacheGeometryPkg::LineData memReadData,
    output logic memWriteReq,
    input logic memWriteGrant,
    output cacheGeometryPkg::LineData memWriteData
);
    import cacheGeometryPkg::*;

    arrayAccessIf #(.entryType(TagEntry), .indexWidth(indexWidth)) tagPort();
    arrayAccessIf #(.entryType(LineData), .indexWidth(indexWidth)) dataPort();
    lineTransferIf #(.indexWidth(indexWidth)) xfer();

    // Tags start invalid after reset
    syncArray #(
        .entryType(TagEntry),
        .indexWidth(indexWidth),
        .clearOnReset(1'b1)
    ) tagArray (
        .clk(clk),
        .rst(rst),
        .port(tagPort)
    );

    syncArray #(
        .entryType(LineData),
        .indexWidth(indexWidth),
        .clearOnReset(1'b0)
    ) dataArray (
        .clk(clk),
        .rst(rst),
        .port(dataPort)
    );

    lineTransfer #(.indexWidth(indexWidth)) transfer (
        .clk(clk),
        .rst(rst),
        .xfer(xfer),
        .memAddr(memAddr),
        .memReadReq(memReadReq),
        .memReadGrant(memReadGrant),
        .memReadData(memReadData),
        .memWriteReq(memWriteReq),
        .memWriteGrant(memWriteGrant),
        .memWriteData(memWriteData)
    );

    lsuControl #(.indexWidth(indexWidth)) control (
        .clk(clk),
        .rst(rst),
        .enable(enable),
        .command(command),
        .size(size),
        .isUnsigned(isUnsigned),
        .atomicOp(atomicOp),
        .base(base),
        .imm(imm),
        .storeData(storeData),
        .done(done),
        .result(result),
        .tagPort(tagPort),
        .dataPort(dataPort),
        .xfer(xfer)
    );

endmodule

//--- tests/lsuClockGen.sv
`timescale 1ns/1ps

module lsuClockGen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tests/lsuBind_sva.sv
`timescale 1ns/1ps

module lsuProtocolChecks (
    input logic clk,
    input logic rst,
    input logic done,
    input cacheGeometryPkg::PhysAddr memAddr,
    input logic memReadReq,
    input logic memReadGrant,
    input logic memWriteReq,
    input logic memWriteGrant,
    input cacheGeometryPkg::LineData memWriteData
);

    int violationCount = 0;

    // Read request waits for its grant on a fixed address
    readHeld: assert property (@(posedge clk) disable iff (rst)
        memReadReq && !memReadGrant |=> memReadReq && $stable(memAddr))
        else begin
            $error("read request dropped or moved before its grant");
            violationCount++;
        end

    writeHeld: assert property (@(posedge clk) disable iff (rst)
        memWriteReq && !memWriteGrant |=> memWriteReq && $stable(memAddr)
            && $stable(memWriteData))
        else begin
            $error("write request dropped or changed before its grant");
            violationCount++;
        end

    donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for two cycles");
            violationCount++;
        end

    oneRequest: assert property (@(posedge clk) disable iff (rst)
        !(memReadReq && memWriteReq))
        else begin
            $error("read and write requests raised together");
            violationCount++;
        end

endmodule

bind loadStoreUnit lsuProtocolChecks protocolChecks (
    .clk(clk),
    .rst(rst),
    .done(done),
    .memAddr(memAddr),
    .memReadReq(memReadReq),
    .memReadGrant(memReadGrant),
    .memWriteReq(memWriteReq),
    .memWriteGrant(memWriteGrant),
    .memWriteData(memWriteData)
);

//--- tests/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;
    import cacheGeometryPkg::*;
    import lsuOpsPkg::*;

    // Small index so that the 1 KB window conflicts in the cache
    localparam int indexWidth = 4;
    localparam int numCommands = 400;
    localparam int windowBytes = 1024;

    logic clk;
    logic rst;
    logic enable;
    LsuCommand command;
    AccessSize size;
    logic isUnsigned;
    AtomicOp atomicOp;
    PhysAddr base;
    Word imm;
    Word storeData;
    logic done;
    Word result;
    PhysAddr memAddr;
    logic memReadReq;
    logic memReadGrant = 1'b0;
    LineData memReadData = '0;
    logic memWriteReq;
    logic memWriteGrant = 1'b0;
    LineData memWriteData;

    logic [7:0] memBytes [windowBytes];
    logic [7:0] refMem [windowBytes];
    logic shadowValid [1 << indexWidth];
    LineAddr shadowTag [1 << indexWidth];

    logic [31:0] rngState = 32'heaac;
    logic [31:0] delayState = 32'heaac;
    int errorCount = 0;
    int memErrorCount = 0;
    int commandCount = 0;
    int readCount = 0;
    int writeCount = 0;
    int grantWait = 0;
    logic grantArmed = 1'b0;
    int lineBase;

    lsuClockGen clockGen (.clk(clk), .rst(rst));

    loadStoreUnit #(.indexWidth(indexWidth)) uut (
        .clk(clk),
        .rst(rst),
        .enable(enable),
        .command(command),
        .size(size),
        .isUnsigned(isUnsigned),
        .atomicOp(atomicOp),
        .base(base),
        .imm(imm),
        .storeData(storeData),
        .done(done),
        .result(result),
        .memAddr(memAddr),
        .memReadReq(memReadReq),
        .memReadGrant(memReadGrant),
        .memReadData(memReadData),
        .memWriteReq(memWriteReq),
        .memWriteGrant(memWriteGrant),
        .memWriteData(memWriteData)
    );

    function automatic logic [31:0] lcgStep(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic drawRandom(output int value);
        rngState = lcgStep(rngState);
        value = int'(rngState[31:16]);
    endtask

    function automatic logic [7:0] fillByte(input int byteAddr);
        logic [31:0] mixed;
        mixed = byteAddr * 32'h9e3779b1;
        return mixed[31:24] ^ mixed[15:8];
    endfunction

    function automatic LineData memLine(input int baseIdx);
        LineData line;
        for (int i = 0; i < lineBytes; i++) begin
            line[i*8 +: 8] = memBytes[baseIdx + i];
        end
        return line;
    endfunction

    function automatic LineData modelLine(input int baseIdx);
        LineData line;
        for (int i = 0; i < lineBytes; i++) begin
            line[i*8 +: 8] = refMem[baseIdx + i];
        end
        return line;
    endfunction

    function automatic Word modelWord(input int idx);
        return {refMem[idx + 3], refMem[idx + 2], refMem[idx + 1], refMem[idx]};
    endfunction

    function automatic Word memWord(input int idx);
        return {memBytes[idx + 3], memBytes[idx + 2], memBytes[idx + 1], memBytes[idx]};
    endfunction

    function automatic Word expectedLoad(input int idx, input AccessSize sz, input logic uns);
        logic [15:0] half;
        logic [7:0] single;
        half = {refMem[idx + 1], refMem[idx]};
        single = refMem[idx];
        case (sz)
            sizeByte: return uns ? {24'h0, single} : {{24{single[7]}}, single};
            sizeHalf: return uns ? {16'h0, half} : {{16{half[15]}}, half};
            default: return modelWord(idx);
        endcase
    endfunction

    // RISC-V AMO rules, regValue comes from the requester
    function automatic Word applyAtomic(input AtomicOp op, input Word regValue, input Word memValue);
        case (op)
            opSwap: return regValue;
            opAdd: return regValue + memValue;
            opXor: return regValue ^ memValue;
            opAnd: return regValue & memValue;
            opOr: return regValue | memValue;
            opMin: return ($signed(memValue) > $signed(regValue)) ? regValue : memValue;
            opMax: return ($signed(memValue) > $signed(regValue)) ? memValue : regValue;
            opMinu: return (memValue > regValue) ? regValue : memValue;
            opMaxu: return (memValue > regValue) ? memValue : regValue;
            default: return memValue;
        endcase
    endfunction

    task automatic writeModel(input int idx, input AccessSize sz, input Word data);
        int count;
        count = 1 << sz;
        for (int i = 0; i < count; i++) begin
            refMem[idx + i] = data[i*8 +: 8];
        end
    endtask

    task automatic checkResetOutputs();
        if (done !== 1'b0 || memReadReq !== 1'b0 || memWriteReq !== 1'b0) begin
            errorCount++;
            $display("FAIL reset outputs: done %h memReadReq %h memWriteReq %h",
                done, memReadReq, memWriteReq);
        end
    endtask

    task automatic runCommand(input LsuCommand cmd, input AccessSize sz, input logic uns,
            input AtomicOp op, input PhysAddr addr, input Word data);
        int idx;
        int wordIdx;
        int slot;
        int immPick;
        int readsBefore;
        int writesBefore;
        int readsExpected;
        int writesExpected;
        logic hitExpected;
        Word immValue;
        Word expected;
        Word oldWord;
        Word newWord;
        idx = int'(addr[9:0]);
        wordIdx = idx & ~3;
        slot = int'(addr[offsetWidth+indexWidth-1:offsetWidth]);
        hitExpected = shadowValid[slot] && (shadowTag[slot] == addr[addrWidth-1:offsetWidth]);
        expected = expectedLoad(idx, sz, uns);
        oldWord = modelWord(wordIdx);
        newWord = applyAtomic(op, data, oldWord);
        if (cmd == cmdStore) begin
            writeModel(idx, sz, data);
        end else if (cmd == cmdAtomic) begin
            writeModel(wordIdx, sizeWord, newWord);
        end
        readsExpected = (cmd != cmdInvalidate && !hitExpected) ? 1 : 0;
        writesExpected = (cmd == cmdStore || cmd == cmdAtomic) ? 1 : 0;
        drawRandom(immPick);
        immValue = {{16{immPick[15]}}, immPick[15:0]};
        readsBefore = readCount;
        writesBefore = writeCount;
        commandCount++;

        @(posedge clk);
        enable <= 1'b1;
        command <= cmd;
        size <= sz;
        isUnsigned <= uns;
        atomicOp <= op;
        imm <= immValue;
        base <= addr - immValue;
        storeData <= data;
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
        enable <= 1'b0;
        command <= cmdNone;

        if (cmd == cmdLoad && result !== expected) begin
            errorCount++;
            $display("FAIL result: addr %h expected %h actual %h", addr, expected, result);
        end
        if (cmd == cmdAtomic && result !== oldWord) begin
            errorCount++;
            $display("FAIL result: atomic addr %h expected %h actual %h", addr, oldWord, result);
        end
        if (cmd == cmdAtomic && memWord(wordIdx) !== newWord) begin
            errorCount++;
            $display("FAIL memWriteData: atomic addr %h expected %h actual %h",
                addr, newWord, memWord(wordIdx));
        end
        if (readCount - readsBefore != readsExpected) begin
            errorCount++;
            $display("FAIL memReadReq: fetches at addr %h expected %h actual %h",
                addr, readsExpected, readCount - readsBefore);
        end
        if (writeCount - writesBefore != writesExpected) begin
            errorCount++;
            $display("FAIL memWriteReq: writes at addr %h expected %h actual %h",
                addr, writesExpected, writeCount - writesBefore);
        end

        if (cmd == cmdInvalidate) begin
            for (int i = 0; i < (1 << indexWidth); i++) begin
                shadowValid[i] = 1'b0;
            end
        end else begin
            shadowValid[slot] = 1'b1;
            shadowTag[slot] = addr[addrWidth-1:offsetWidth];
        end
    endtask

    // Memory responder with random grant delay
    always @(posedge clk) begin
        if (rst) begin
            memReadGrant <= 1'b0;
            memWriteGrant <= 1'b0;
            grantArmed = 1'b0;
            for (int i = 0; i < windowBytes; i++) begin
                memBytes[i] = fillByte(i);
            end
        end else if (memReadGrant || memWriteGrant) begin
            memReadGrant <= 1'b0;
            memWriteGrant <= 1'b0;
        end else if (memReadReq || memWriteReq) begin
            if (!grantArmed) begin
                delayState = lcgStep(delayState);
                grantWait = int'(delayState[31:16]) % 6;
                grantArmed = 1'b1;
            end
            if (grantWait == 0) begin
                grantArmed = 1'b0;
                lineBase = int'(memAddr[9:0]);
                if (memAddr[addrWidth-1:10] != '0) begin
                    memErrorCount++;
                    $display("Memory address %h is outside the test window", memAddr);
                end
                if (memReadReq) begin
                    memReadData <= memLine(lineBase);
                    memReadGrant <= 1'b1;
                    readCount++;
                end else begin
                    if (memWriteData !== modelLine(lineBase)) begin
                        memErrorCount++;
                        $display("FAIL memWriteData: addr %h expected %h actual %h",
                            memAddr, modelLine(lineBase), memWriteData);
                    end
                    for (int i = 0; i < lineBytes; i++) begin
                        memBytes[lineBase + i] = memWriteData[i*8 +: 8];
                    end
                    memWriteGrant <= 1'b1;
                    writeCount++;
                end
            end else begin
                grantWait--;
            end
        end
    end

    initial begin
        #(numCommands * 200 * 4);
        $display("Timeout: the DUT did not finish the commands in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        int pick;
        int pickLow;
        int choice;
        int total;
        LsuCommand cmd;
        AccessSize sz;
        logic uns;
        AtomicOp op;
        PhysAddr addr;
        Word data;
        enable = 1'b0;
        command = cmdNone;
        size = sizeWord;
        isUnsigned = 1'b0;
        atomicOp = opSwap;
        base = '0;
        imm = '0;
        storeData = '0;
        for (int i = 0; i < windowBytes; i++) begin
            refMem[i] = fillByte(i);
        end
        for (int i = 0; i < (1 << indexWidth); i++) begin
            shadowValid[i] = 1'b0;
            shadowTag[i] = '0;
        end

        // Outputs stay low once the first reset edge has passed
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
            checkResetOutputs();
        end
        @(posedge clk);
        checkResetOutputs();

        for (int n = 0; n < numCommands; n++) begin
            drawRandom(pick);
            choice = pick % 16;
            if (choice < 7) begin
                cmd = cmdLoad;
            end else if (choice < 12) begin
                cmd = cmdStore;
            end else if (choice < 15) begin
                cmd = cmdAtomic;
            end else begin
                cmd = cmdInvalidate;
            end
            drawRandom(pick);
            sz = (cmd == cmdAtomic) ? sizeWord : AccessSize'(pick % 3);
            uns = pick[4];
            op = AtomicOp'((pick >> 5) % 9);
            drawRandom(pick);
            addr = PhysAddr'(pick & (windowBytes - 1) & ~((1 << sz) - 1));
            drawRandom(pick);
            drawRandom(pickLow);
            data = {pick[15:0], pickLow[15:0]};
            runCommand(cmd, sz, uns, op, addr, data);
            // Read back some stores right away
            if (cmd == cmdStore && data[3]) begin
                runCommand(cmdLoad, sz, uns, opSwap, addr, '0);
            end
        end

        total = errorCount + memErrorCount + uut.protocolChecks.violationCount;
        $display("Commands %0d, check errors %0d, memory errors %0d, assertion failures %0d",
            commandCount, errorCount, memErrorCount, uut.protocolChecks.violationCount);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/cacheGeometryPkg.sv
verilog/lsuOpsPkg.sv
verilog/arrayAccessIf.sv
verilog/lineTransferIf.sv
verilog/syncArray.sv
verilog/lineTransfer.sv
verilog/lsuControl.sv
verilog/loadStoreUnit.sv
tests/lsuClockGen.sv
tests/lsuBind_sva.sv
tests/lsuTb.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f verilog.f --top-module lsuTb -o lsuSim

output=$(./obj_dir/lsuSim +verilator+error+limit+1000 || true)
echo "$output"

if echo "$output" | grep -q "all tests passed"; then
    exit 0
fi
exit 1
